//--- verilog/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// core-local timer window, mtime low word then high word
`define LSU_TIMER_BASE 32'ha0000048
`define LSU_TIMER_END  32'ha000004f

// on-chip memory, indexed by address bits 9 to 2
`define LSU_MEM_WORDS 256
`define LSU_MEM_AW    8

`endif

//--- verilog/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // access width, same coding as the core's mask field
    typedef enum logic [1:0] {
        SIZE_NONE = 2'b00,
        SIZE_BYTE = 2'b01,
        SIZE_HALF = 2'b10,
        SIZE_WORD = 2'b11
    } access_size_e;

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_BUS,
        LSU_TIMER,
        LSU_DONE
    } lsu_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FETCH,
        ARB_LSU
    } arb_state_e;

    // request payload, addr is word aligned
    typedef struct packed {
        logic [31:0] addr;
        logic        wen;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

//--- verilog/lsu.sv
`default_nettype none

`include "lsu_cfg.svh"

module lsu (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  core_req,
    input  wire logic                  core_wen,
    input  wire logic                  core_sign,
    input  wire lsu_pkg::access_size_e core_size,
    input  wire logic [31:0]           core_addr,
    input  wire logic [31:0]           core_wdata,
    output logic                       core_ack,
    output logic [31:0]                core_rdata,
    output logic                       bus_req,
    output lsu_pkg::bus_req_t          bus_out,
    input  wire logic                  bus_ack,
    input  wire lsu_pkg::bus_rsp_t     bus_in,
    output logic                       tmr_req,
    output logic                       tmr_hi,
    input  wire logic                  tmr_ack,
    input  wire logic [31:0]           tmr_rdata
);

    lsu_pkg::lsu_state_e   state_q;
    logic [31:0]           addr_q;
    logic                  wen_q;
    logic                  sign_q;
    lsu_pkg::access_size_e size_q;
    logic [31:0]           wdata_q;
    logic [3:0]            wstrb_q;
    logic                  is_tmr_q;

    logic                  in_window;
    logic [3:0]            wstrb_d;
    logic [31:0]           wdata_d;
    logic [31:0]           tmr_off;
    logic [31:0]           rsp_word;
    logic [31:0]           rsp_shift;
    logic [31:0]           load_ext;
    logic                  down_ack;

    assign in_window = (core_addr >= `LSU_TIMER_BASE) && (core_addr <= `LSU_TIMER_END);

    // byte lanes touched by a store
    always_comb begin
        case (core_size)
            lsu_pkg::SIZE_BYTE: wstrb_d = 4'b0001 << core_addr[1:0];
            lsu_pkg::SIZE_HALF: wstrb_d = core_addr[1] ? 4'b1100 : 4'b0011;
            lsu_pkg::SIZE_WORD: wstrb_d = 4'b1111;
            default:            wstrb_d = 4'b0000;
        endcase
    end

    assign wdata_d = core_wdata << {core_addr[1:0], 3'b000};

    // load path, move the addressed byte down to bit 0 then extend
    assign rsp_word  = is_tmr_q ? tmr_rdata : bus_in.rdata;
    assign rsp_shift = rsp_word >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (size_q)
            lsu_pkg::SIZE_BYTE: load_ext = {{24{rsp_shift[7] & sign_q}}, rsp_shift[7:0]};
            lsu_pkg::SIZE_HALF: load_ext = {{16{rsp_shift[15] & sign_q}}, rsp_shift[15:0]};
            lsu_pkg::SIZE_WORD: load_ext = rsp_shift;
            default:            load_ext = 32'h0;
        endcase
    end

    assign down_ack = is_tmr_q ? tmr_ack : bus_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= lsu_pkg::LSU_IDLE;
        end else begin
            case (state_q)
                lsu_pkg::LSU_IDLE: begin
                    if (core_req) begin
                        state_q <= in_window ? lsu_pkg::LSU_TIMER : lsu_pkg::LSU_BUS;
                    end
                end
                lsu_pkg::LSU_BUS, lsu_pkg::LSU_TIMER: begin
                    if (down_ack) begin
                        state_q <= lsu_pkg::LSU_DONE;
                    end
                end
                lsu_pkg::LSU_DONE: begin
                    // both sides must be back to zero
                    if (!core_req && !down_ack) begin
                        state_q <= lsu_pkg::LSU_IDLE;
                    end
                end
                default: state_q <= lsu_pkg::LSU_IDLE;
            endcase
        end
    end

    // request latch and load result
    always_ff @(posedge clk) begin
        if (state_q == lsu_pkg::LSU_IDLE && core_req) begin
            addr_q   <= core_addr;
            wen_q    <= core_wen;
            sign_q   <= core_sign;
            size_q   <= core_size;
            wdata_q  <= wdata_d;
            wstrb_q  <= wstrb_d;
            is_tmr_q <= in_window;
        end
        if ((state_q == lsu_pkg::LSU_BUS || state_q == lsu_pkg::LSU_TIMER) && down_ack) begin
            core_rdata <= load_ext;
        end
    end

    // timer writes go out as plain reads and are dropped there
    assign tmr_off = addr_q - `LSU_TIMER_BASE;
    assign tmr_hi  = tmr_off[2];
    assign tmr_req = (state_q == lsu_pkg::LSU_TIMER);

    assign bus_req = (state_q == lsu_pkg::LSU_BUS);

    always_comb begin
        bus_out.addr  = {addr_q[31:2], 2'b00};
        bus_out.wen   = wen_q;
        bus_out.wstrb = wstrb_q;
        bus_out.wdata = wdata_q;
    end

    assign core_ack = (state_q == lsu_pkg::LSU_DONE);

endmodule

`default_nettype wire

//--- verilog/fetch_port.sv
`default_nettype none

module fetch_port (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              fetch_req,
    input  wire logic [31:0]       pc,
    output logic                   fetch_ack,
    output logic [31:0]            instr,
    output logic                   fault,
    output logic                   bus_req,
    output lsu_pkg::bus_req_t      bus_out,
    input  wire logic              bus_ack,
    input  wire lsu_pkg::bus_rsp_t bus_in
);

    logic bus_req_q;
    logic ack_q;
    logic fault_q;
    logic start;

    // a new fetch only when both handshakes are idle
    assign start = fetch_req && !bus_req_q && !ack_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_req_q <= 1'b0;
            ack_q     <= 1'b0;
            fault_q   <= 1'b0;
        end else begin
            if (start) begin
                if (pc[1:0] != 2'b00) begin
                    // misaligned, answer at once without a bus cycle
                    fault_q <= 1'b1;
                    ack_q   <= 1'b1;
                end else begin
                    fault_q   <= 1'b0;
                    bus_req_q <= 1'b1;
                end
            end else if (bus_req_q && bus_ack) begin
                bus_req_q <= 1'b0;
                ack_q     <= 1'b1;
            end else if (ack_q && !fetch_req && !bus_ack) begin
                ack_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_req_q && bus_ack) begin
            instr <= bus_in.rdata;
        end
    end

    assign bus_req   = bus_req_q;
    assign fetch_ack = ack_q;
    assign fault     = fault_q;

    always_comb begin
        bus_out.addr  = {pc[31:2], 2'b00};
        bus_out.wen   = 1'b0;
        bus_out.wstrb = 4'b0000;
        bus_out.wdata = 32'h0;
    end

endmodule

`default_nettype wire

//--- verilog/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              if_req,
    input  wire lsu_pkg::bus_req_t if_in,
    output logic                   if_ack,
    input  wire logic              lsu_req,
    input  wire lsu_pkg::bus_req_t lsu_in,
    output logic                   lsu_ack,
    output lsu_pkg::bus_rsp_t      rsp_out,
    output logic                   mem_req,
    output lsu_pkg::bus_req_t      mem_out,
    input  wire logic              mem_ack,
    input  wire lsu_pkg::bus_rsp_t mem_in
);

    lsu_pkg::arb_state_e grant_q;
    // set when the lsu had the last grant
    logic                last_lsu_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_q    <= lsu_pkg::ARB_IDLE;
            last_lsu_q <= 1'b0;
        end else begin
            case (grant_q)
                lsu_pkg::ARB_IDLE: begin
                    if (if_req && (!lsu_req || last_lsu_q)) begin
                        grant_q    <= lsu_pkg::ARB_FETCH;
                        last_lsu_q <= 1'b0;
                    end else if (lsu_req) begin
                        grant_q    <= lsu_pkg::ARB_LSU;
                        last_lsu_q <= 1'b1;
                    end
                end
                lsu_pkg::ARB_FETCH: begin
                    if (!if_req && !mem_ack) begin
                        grant_q <= lsu_pkg::ARB_IDLE;
                    end
                end
                lsu_pkg::ARB_LSU: begin
                    if (!lsu_req && !mem_ack) begin
                        grant_q <= lsu_pkg::ARB_IDLE;
                    end
                end
                default: grant_q <= lsu_pkg::ARB_IDLE;
            endcase
        end
    end

    // steering follows the grant register only
    always_comb begin
        case (grant_q)
            lsu_pkg::ARB_FETCH: mem_req = if_req;
            lsu_pkg::ARB_LSU:   mem_req = lsu_req;
            default:            mem_req = 1'b0;
        endcase
    end

    assign mem_out = (grant_q == lsu_pkg::ARB_LSU) ? lsu_in : if_in;
    assign if_ack  = (grant_q == lsu_pkg::ARB_FETCH) && mem_ack;
    assign lsu_ack = (grant_q == lsu_pkg::ARB_LSU) && mem_ack;
    assign rsp_out = mem_in;

endmodule

`default_nettype wire

//--- verilog/sram_slave.sv
`default_nettype none

`include "lsu_cfg.svh"

module sram_slave (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              req,
    input  wire lsu_pkg::bus_req_t req_in,
    output logic                   ack,
    output lsu_pkg::bus_rsp_t      rsp_out
);

    logic [31:0]             mem [`LSU_MEM_WORDS];
    logic [`LSU_MEM_AW-1:0]  idx;
    logic                    ack_q;
    logic                    accept;

    // upper address bits are ignored, so the memory aliases
    assign idx    = req_in.addr[`LSU_MEM_AW+1:2];
    assign accept = req && !ack_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else if (accept) begin
            ack_q <= 1'b1;
        end else if (!req && ack_q) begin
            ack_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_out.rdata <= mem[idx];
            for (int i = 0; i < 4; i++) begin
                if (req_in.wen && req_in.wstrb[i]) begin
                    mem[idx][8*i +: 8] <= req_in.wdata[8*i +: 8];
                end
            end
        end
    end

    assign ack = ack_q;

endmodule

`default_nettype wire

//--- verilog/clint_timer.sv
`default_nettype none

module clint_timer (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        req,
    input  wire logic        hi,
    output logic             ack,
    output logic [31:0]      rdata
);

    logic [63:0] mtime_q;
    logic        ack_q;

    // free running, no compare or interrupt
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q <= 64'h0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else if (req && !ack_q) begin
            ack_q <= 1'b1;
        end else if (!req && ack_q) begin
            ack_q <= 1'b0;
        end
    end

    // snapshot of the selected half when the request is seen
    always_ff @(posedge clk) begin
        if (req && !ack_q) begin
            rdata <= hi ? mtime_q[63:32] : mtime_q[31:0];
        end
    end

    assign ack = ack_q;

endmodule

`default_nettype wire

//--- verilog/soc_top.sv
`default_nettype none

module soc_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  core_req,
    input  wire logic                  core_wen,
    input  wire logic                  core_sign,
    input  wire lsu_pkg::access_size_e core_size,
    input  wire logic [31:0]           core_addr,
    input  wire logic [31:0]           core_wdata,
    output logic                       core_ack,
    output logic [31:0]                core_rdata,
    input  wire logic                  fetch_req,
    input  wire logic [31:0]           pc,
    output logic                       fetch_ack,
    output logic [31:0]                instr,
    output logic                       fault
);

    logic              lsu_bus_req;
    logic              lsu_bus_ack;
    lsu_pkg::bus_req_t lsu_bus_out;
    logic              if_bus_req;
    logic              if_bus_ack;
    lsu_pkg::bus_req_t if_bus_out;
    lsu_pkg::bus_rsp_t bus_rsp;
    logic              mem_req;
    logic              mem_ack;
    lsu_pkg::bus_req_t mem_out;
    lsu_pkg::bus_rsp_t mem_rsp;
    logic              tmr_req;
    logic              tmr_hi;
    logic              tmr_ack;
    logic [31:0]       tmr_rdata;

    lsu u_lsu (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_req   (core_req),
        .core_wen   (core_wen),
        .core_sign  (core_sign),
        .core_size  (core_size),
        .core_addr  (core_addr),
        .core_wdata (core_wdata),
        .core_ack   (core_ack),
        .core_rdata (core_rdata),
        .bus_req    (lsu_bus_req),
        .bus_out    (lsu_bus_out),
        .bus_ack    (lsu_bus_ack),
        .bus_in     (bus_rsp),
        .tmr_req    (tmr_req),
        .tmr_hi     (tmr_hi),
        .tmr_ack    (tmr_ack),
        .tmr_rdata  (tmr_rdata)
    );

    fetch_port u_fetch_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .pc        (pc),
        .fetch_ack (fetch_ack),
        .instr     (instr),
        .fault     (fault),
        .bus_req   (if_bus_req),
        .bus_out   (if_bus_out),
        .bus_ack   (if_bus_ack),
        .bus_in    (bus_rsp)
    );

    // fetch and lsu share the single memory port
    bus_arbiter u_bus_arbiter (
        .clk     (clk),
        .rst_n   (rst_n),
        .if_req  (if_bus_req),
        .if_in   (if_bus_out),
        .if_ack  (if_bus_ack),
        .lsu_req (lsu_bus_req),
        .lsu_in  (lsu_bus_out),
        .lsu_ack (lsu_bus_ack),
        .rsp_out (bus_rsp),
        .mem_req (mem_req),
        .mem_out (mem_out),
        .mem_ack (mem_ack),
        .mem_in  (mem_rsp)
    );

    sram_slave u_sram_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (mem_req),
        .req_in  (mem_out),
        .ack     (mem_ack),
        .rsp_out (mem_rsp)
    );

    clint_timer u_clint_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (tmr_req),
        .hi    (tmr_hi),
        .ack   (tmr_ack),
        .rdata (tmr_rdata)
    );

endmodule

`default_nettype wire

//--- test/clk_gen.sv
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset released on a falling edge after five rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/tb_soc.sv
`default_nettype none

`include "lsu_cfg.svh"

module tb_soc;
    timeunit 1ns;
    timeprecision 100ps;

    // about 90 accesses of up to 7 cycles each with a margin of two
    localparam int ACCESSES          = 90;
    localparam int CYCLES_PER_ACCESS = 7;
    localparam int MAX_CYCLES        = 2 * ACCESSES * CYCLES_PER_ACCESS;

    logic                  clk;
    logic                  rst_n;
    logic                  core_req;
    logic                  core_wen;
    logic                  core_sign;
    lsu_pkg::access_size_e core_size;
    logic [31:0]           core_addr;
    logic [31:0]           core_wdata;
    logic                  core_ack;
    logic [31:0]           core_rdata;
    logic                  fetch_req;
    logic [31:0]           pc;
    logic                  fetch_ack;
    logic [31:0]           instr;
    logic                  fault;

    // byte image of the low 1 KiB of memory
    logic [7:0]  ref_mem [0:4*`LSU_MEM_WORDS-1];
    logic [31:0] lfsr_q;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    soc_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_req   (core_req),
        .core_wen   (core_wen),
        .core_sign  (core_sign),
        .core_size  (core_size),
        .core_addr  (core_addr),
        .core_wdata (core_wdata),
        .core_ack   (core_ack),
        .core_rdata (core_rdata),
        .fetch_req  (fetch_req),
        .pc         (pc),
        .fetch_ack  (fetch_ack),
        .instr      (instr),
        .fault      (fault)
    );

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = 32'h0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = next_lfsr(lfsr_q);
        end
        return r;
    endfunction

    function automatic logic [31:0] random_word_addr();
        logic [31:0] r;
        r = rand_bits(`LSU_MEM_AW);
        return {r[29:0], 2'b00};
    endfunction

    // little endian read of the byte model
    function automatic logic [31:0] predict_load(input lsu_pkg::access_size_e size,
                                                 input logic sign, input logic [31:0] addr);
        logic [9:0]  i;
        logic [15:0] h;
        i = addr[9:0];
        h = {ref_mem[i + 10'd1], ref_mem[i]};
        case (size)
            lsu_pkg::SIZE_BYTE: return {{24{sign & ref_mem[i][7]}}, ref_mem[i]};
            lsu_pkg::SIZE_HALF: return {{16{sign & h[15]}}, h};
            lsu_pkg::SIZE_WORD: return {ref_mem[i + 10'd3], ref_mem[i + 10'd2], h};
            default:            return 32'h0;
        endcase
    endfunction

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Mismatch at %0d ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic require(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("at %0d ns: %s", $time, what);
        end
    endtask

    // one four-phase core transaction entered and left on a falling edge
    task automatic core_access(input logic wen, input logic sign,
                               input lsu_pkg::access_size_e size, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        core_req   = 1'b1;
        core_wen   = wen;
        core_sign  = sign;
        core_size  = size;
        core_addr  = addr;
        core_wdata = wdata;
        @(negedge clk);
        while (!core_ack) @(negedge clk);
        rdata    = core_rdata;
        core_req = 1'b0;
        @(negedge clk);
        while (core_ack) @(negedge clk);
    endtask

    task automatic fetch_word(input logic [31:0] addr, output logic [31:0] word,
                              output logic flt);
        fetch_req = 1'b1;
        pc        = addr;
        @(negedge clk);
        while (!fetch_ack) @(negedge clk);
        word      = instr;
        flt       = fault;
        fetch_req = 1'b0;
        @(negedge clk);
        while (fetch_ack) @(negedge clk);
    endtask

    task automatic store_mem(input lsu_pkg::access_size_e size, input logic [31:0] addr,
                             input logic [31:0] data);
        logic [31:0] unused_rd;
        logic [9:0]  i;
        core_access(1'b1, 1'b0, size, addr, data, unused_rd);
        i = addr[9:0];
        ref_mem[i] = data[7:0];
        if (size != lsu_pkg::SIZE_BYTE) begin
            ref_mem[i + 10'd1] = data[15:8];
        end
        if (size == lsu_pkg::SIZE_WORD) begin
            ref_mem[i + 10'd2] = data[23:16];
            ref_mem[i + 10'd3] = data[31:24];
        end
    endtask

    task automatic load_and_compare(input lsu_pkg::access_size_e size, input logic sign,
                                    input logic [31:0] addr);
        logic [31:0] got;
        core_access(1'b0, sign, size, addr, 32'h0, got);
        compare_word("core_rdata", predict_load(size, sign, addr), got);
    endtask

    task automatic word_store_load();
        logic [31:0] a;
        compare_word("core_ack", 32'h0, 32'(core_ack));
        compare_word("fetch_ack", 32'h0, 32'(fetch_ack));
        for (int i = 0; i < 8; i++) begin
            a = random_word_addr();
            store_mem(lsu_pkg::SIZE_WORD, a, rand_bits(32));
            load_and_compare(lsu_pkg::SIZE_WORD, 1'b0, a);
        end
    endtask

    task automatic partial_stores();
        logic [31:0] a;
        for (int w = 0; w < 2; w++) begin
            a = random_word_addr();
            store_mem(lsu_pkg::SIZE_WORD, a, rand_bits(32));
            for (int off = 0; off < 4; off++) begin
                store_mem(lsu_pkg::SIZE_BYTE, a + 32'(off), rand_bits(32));
                load_and_compare(lsu_pkg::SIZE_WORD, 1'b0, a);
            end
            for (int off = 0; off < 4; off += 2) begin
                store_mem(lsu_pkg::SIZE_HALF, a + 32'(off), rand_bits(32));
                load_and_compare(lsu_pkg::SIZE_WORD, 1'b0, a);
            end
        end
    endtask

    task automatic partial_loads();
        logic [31:0] a;
        for (int w = 0; w < 2; w++) begin
            a = random_word_addr();
            // first word mixes positive and negative bytes and halves
            store_mem(lsu_pkg::SIZE_WORD, a, (w == 0) ? 32'h7f80_ff01 : rand_bits(32));
            for (int s = 0; s < 2; s++) begin
                for (int off = 0; off < 4; off++) begin
                    load_and_compare(lsu_pkg::SIZE_BYTE, 1'(s), a + 32'(off));
                end
                for (int off = 0; off < 4; off += 2) begin
                    load_and_compare(lsu_pkg::SIZE_HALF, 1'(s), a + 32'(off));
                end
            end
        end
    endtask

    task automatic fetch_lsu_data();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] word;
        logic [31:0] rd;
        logic        flt;
        a = random_word_addr();
        store_mem(lsu_pkg::SIZE_WORD, a, rand_bits(32));
        fetch_word(a, word, flt);
        compare_word("instr", predict_load(lsu_pkg::SIZE_WORD, 1'b0, a), word);
        compare_word("fault", 32'h0, 32'(flt));
        for (int i = 0; i < 2; i++) begin
            a = random_word_addr();
            b = random_word_addr();
            store_mem(lsu_pkg::SIZE_WORD, a, rand_bits(32));
            store_mem(lsu_pkg::SIZE_WORD, b, rand_bits(32));
            // a lone fetch makes the lsu the next winner
            if (i == 1) begin
                fetch_word(a, word, flt);
            end
            fork
                fetch_word(a, word, flt);
                core_access(1'b0, 1'b0, lsu_pkg::SIZE_WORD, b, 32'h0, rd);
            join
            compare_word("instr", predict_load(lsu_pkg::SIZE_WORD, 1'b0, a), word);
            compare_word("fault", 32'h0, 32'(flt));
            compare_word("core_rdata", predict_load(lsu_pkg::SIZE_WORD, 1'b0, b), rd);
        end
    endtask

    task automatic misaligned_fetch();
        logic [31:0] a;
        logic [31:0] word;
        logic        flt;
        a = random_word_addr();
        store_mem(lsu_pkg::SIZE_WORD, a, rand_bits(32));
        for (int off = 1; off < 4; off++) begin
            fetch_word(a + 32'(off), word, flt);
            compare_word("fault", 32'h1, 32'(flt));
        end
        load_and_compare(lsu_pkg::SIZE_WORD, 1'b0, a);
    endtask

    task automatic timer_reads();
        logic [31:0] t0;
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] hi;
        core_access(1'b0, 1'b0, lsu_pkg::SIZE_WORD, `LSU_TIMER_BASE, 32'h0, t0);
        core_access(1'b0, 1'b0, lsu_pkg::SIZE_WORD, `LSU_TIMER_BASE, 32'h0, t1);
        require(t1 > t0, "timer low word did not increase between two reads");
        // write is acked and dropped
        core_access(1'b1, 1'b0, lsu_pkg::SIZE_WORD, `LSU_TIMER_BASE, rand_bits(32), t2);
        core_access(1'b0, 1'b0, lsu_pkg::SIZE_WORD, `LSU_TIMER_BASE, 32'h0, t2);
        require(t2 >= t1, "timer low word went backwards after a timer store");
        core_access(1'b0, 1'b0, lsu_pkg::SIZE_WORD, `LSU_TIMER_BASE + 32'h4, 32'h0, hi);
        compare_word("mtime high word", 32'h0, hi);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        core_req   = 1'b0;
        core_wen   = 1'b0;
        core_sign  = 1'b0;
        core_size  = lsu_pkg::SIZE_NONE;
        core_addr  = 32'h0;
        core_wdata = 32'h0;
        fetch_req  = 1'b0;
        pc         = 32'h0;
        lfsr_q     = 32'h7886;
        @(posedge rst_n);
        @(negedge clk);
        word_store_load();
        partial_stores();
        partial_loads();
        fetch_lsu_data();
        misaligned_fetch();
        timer_reads();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu.sv
verilog/fetch_port.sv
verilog/bus_arbiter.sv
verilog/sram_slave.sv
verilog/clint_timer.sv
verilog/soc_top.sv
test/clk_gen.sv
test/tb_soc.sv

//--- build.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps -f project.f \
    --top-module tb_soc -o sim_tb_soc
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_soc)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
